// File: common/exec_pkg.sv
package exec_pkg;

    localparam int xlen      = 32;
    localparam int div_steps = 32;  // one iteration per quotient bit
    localparam int cnt_w     = 6;   // holds div_steps

    // operation class from the main decoder
    typedef enum logic [2:0] {
        mem_addr = 3'd0,            // load/store address
        branch   = 3'd1,            // compare by subtraction
        reg_op   = 3'd2,            // r-type and i-type arithmetic
        lui      = 3'd3,
        mul_op   = 3'd4,
        div_op   = 3'd5
    } alu_op_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sltu   = 4'd6,
        alu_sll    = 4'd7,
        alu_srl    = 4'd8,
        alu_sra    = 4'd9,
        alu_pass_b = 4'd15          // lui, upper immediate arrives on op_b
    } alu_ctrl_e;

    // order matches funct3[1:0] of the m extension
    typedef enum logic [1:0] {mul, mulh, mulhsu, mulhu} mul_ctrl_e;
    typedef enum logic [1:0] {div, divu, rem, remu} div_ctrl_e;

    typedef enum logic [1:0] {
        unit_alu = 2'd0,
        unit_mul = 2'd1,
        unit_div = 2'd2
    } unit_sel_e;

    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_div_run = 2'd1,
        st_div_fin = 2'd2
    } exec_state_e;

endpackage

// File: logic/alu_decoder.sv
`timescale 1ns/10ps

module alu_decoder (
    input  exec_pkg::alu_op_e   alu_op,         // operation class
    input  logic [2:0]          funct3,
    input  logic                funct7_5,       // alternate encoding bit
    output exec_pkg::alu_ctrl_e alu_ctrl,
    output exec_pkg::mul_ctrl_e mul_ctrl,
    output exec_pkg::div_ctrl_e div_ctrl,
    output exec_pkg::unit_sel_e unit_sel
);

    always_comb begin
        alu_ctrl = exec_pkg::alu_add;
        mul_ctrl = exec_pkg::mul;
        div_ctrl = exec_pkg::div;
        unit_sel = exec_pkg::unit_alu;

        case (alu_op)
            exec_pkg::mem_addr: alu_ctrl = exec_pkg::alu_add;     // base + offset
            exec_pkg::branch:   alu_ctrl = exec_pkg::alu_sub;     // compare by difference
            exec_pkg::lui:      alu_ctrl = exec_pkg::alu_pass_b;
            exec_pkg::reg_op: begin
                case (funct3)
                    3'b000:  alu_ctrl = funct7_5 ? exec_pkg::alu_sub : exec_pkg::alu_add;
                    3'b001:  alu_ctrl = exec_pkg::alu_sll;
                    3'b010:  alu_ctrl = exec_pkg::alu_slt;
                    3'b011:  alu_ctrl = exec_pkg::alu_sltu;
                    3'b100:  alu_ctrl = exec_pkg::alu_xor;
                    3'b101:  alu_ctrl = funct7_5 ? exec_pkg::alu_sra : exec_pkg::alu_srl;
                    3'b110:  alu_ctrl = exec_pkg::alu_or;
                    default: alu_ctrl = exec_pkg::alu_and;        // funct3 = 111
                endcase
            end
            exec_pkg::mul_op: begin
                mul_ctrl = exec_pkg::mul_ctrl_e'(funct3[1:0]);
                unit_sel = exec_pkg::unit_mul;
            end
            exec_pkg::div_op: begin
                div_ctrl = exec_pkg::div_ctrl_e'(funct3[1:0]);  // div, divu, rem, remu
                unit_sel = exec_pkg::unit_div;
            end
            default: ;                                            // defaults above hold
        endcase
    end

endmodule

// File: logic/int_alu.sv
`timescale 1ns/10ps

module int_alu (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [exec_pkg::xlen-1:0] op_a,
    input  logic [exec_pkg::xlen-1:0] op_b,
    input  exec_pkg::alu_ctrl_e       alu_ctrl,
    input  exec_pkg::mul_ctrl_e       mul_ctrl,
    input  exec_pkg::unit_sel_e       unit_sel,
    input  logic                      alu_load,     // capture alu or product
    input  logic                      wb_div,       // capture divider output
    input  logic [exec_pkg::xlen-1:0] div_result,
    output logic [exec_pkg::xlen-1:0] result
);

    localparam int xlen = exec_pkg::xlen;

    logic [xlen-1:0]          alu_res;
    logic [4:0]               shamt;
    logic                     a_sgn;
    logic                     b_sgn;
    logic signed [xlen:0]     a_ext;
    logic signed [xlen:0]     b_ext;
    logic signed [2*xlen-1:0] prod;
    logic [xlen-1:0]          mul_res;

    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_ctrl)
            exec_pkg::alu_add:    alu_res = op_a + op_b;
            exec_pkg::alu_sub:    alu_res = op_a - op_b;
            exec_pkg::alu_and:    alu_res = op_a & op_b;
            exec_pkg::alu_or:     alu_res = op_a | op_b;
            exec_pkg::alu_xor:    alu_res = op_a ^ op_b;
            exec_pkg::alu_slt:    alu_res = xlen'($signed(op_a) < $signed(op_b));
            exec_pkg::alu_sltu:   alu_res = xlen'(op_a < op_b);
            exec_pkg::alu_sll:    alu_res = op_a << shamt;
            exec_pkg::alu_srl:    alu_res = op_a >> shamt;
            exec_pkg::alu_sra:    alu_res = $signed(op_a) >>> shamt;
            exec_pkg::alu_pass_b: alu_res = op_b;
            default:              alu_res = '0;
        endcase
    end

    // one extra bit per operand so a single signed multiplier covers all variants
    assign a_sgn = (mul_ctrl == exec_pkg::mulh) || (mul_ctrl == exec_pkg::mulhsu);
    assign b_sgn = (mul_ctrl == exec_pkg::mulh);
    assign a_ext = {a_sgn & op_a[xlen-1], op_a};
    assign b_ext = {b_sgn & op_b[xlen-1], op_b};
    assign prod  = (2*xlen)'(a_ext) * (2*xlen)'(b_ext);  // 64-bit two's complement product

    assign mul_res = (mul_ctrl == exec_pkg::mul) ? prod[xlen-1:0] : prod[2*xlen-1:xlen];

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (wb_div) begin
            result <= div_result;
        end else if (alu_load) begin
            result <= (unit_sel == exec_pkg::unit_mul) ? mul_res : alu_res;
        end
    end

endmodule

// File: divide/divider.sv
`timescale 1ns/10ps

module divider (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [exec_pkg::xlen-1:0] op_a,         // dividend
    input  logic [exec_pkg::xlen-1:0] op_b,         // divisor
    input  exec_pkg::div_ctrl_e       div_ctrl,
    input  logic                      div_load,
    input  logic                      div_step,
    output logic [exec_pkg::xlen-1:0] div_result
);

    localparam int xlen = exec_pkg::xlen;

    logic            signed_op;
    logic            a_neg;
    logic            b_neg;
    logic [xlen-1:0] a_mag;
    logic [xlen-1:0] b_mag;

    logic [xlen-1:0] quo_q;                         // dividend bits shift out, quotient in
    logic [xlen-1:0] rem_q;
    logic [xlen-1:0] dvs_q;
    logic            neg_q;                         // negate quotient
    logic            neg_r;                         // negate remainder
    logic            dz_q;                          // divisor was zero
    exec_pkg::div_ctrl_e ctrl_q;

    logic [xlen:0]   shifted;
    logic [xlen:0]   trial;
    logic            fits;
    logic [xlen-1:0] q_fix;
    logic [xlen-1:0] r_fix;

    assign signed_op = (div_ctrl == exec_pkg::div) || (div_ctrl == exec_pkg::rem);
    assign a_neg     = signed_op & op_a[xlen-1];
    assign b_neg     = signed_op & op_b[xlen-1];
    assign a_mag     = a_neg ? -op_a : op_a;        // most negative maps to 2**31 and stays exact
    assign b_mag     = b_neg ? -op_b : op_b;

    // each restoring step brings down the next dividend bit and tries a subtract
    assign shifted = {rem_q, quo_q[xlen-1]};
    assign trial   = shifted - {1'b0, dvs_q};
    assign fits    = shifted >= {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (div_load) begin
            quo_q <= a_mag;
            rem_q <= '0;
            dvs_q <= b_mag;
        end else if (div_step) begin
            quo_q <= {quo_q[xlen-2:0], fits};
            rem_q <= fits ? trial[xlen-1:0] : shifted[xlen-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            neg_q  <= 1'b0;
            neg_r  <= 1'b0;
            dz_q   <= 1'b0;
            ctrl_q <= exec_pkg::div;
        end else if (div_load) begin
            neg_q  <= a_neg ^ b_neg;
            neg_r  <= a_neg;                        // remainder follows dividend sign
            dz_q   <= (op_b == '0);
            ctrl_q <= div_ctrl;
        end
    end

    // a zero divisor leaves the dividend magnitude in rem_q, so the remainder needs no special case
    assign q_fix = dz_q ? '1 : (neg_q ? -quo_q : quo_q);
    assign r_fix = neg_r ? -rem_q : rem_q;

    assign div_result = ((ctrl_q == exec_pkg::rem) || (ctrl_q == exec_pkg::remu)) ? r_fix : q_fix;

    a_no_load_during_step: assert property (
        @(posedge clk) disable iff (rst) !(div_load && div_step)
    ) else $error("divider loaded while a division is running");

endmodule

// File: divide/iter_counter.sv
`timescale 1ns/10ps

module iter_counter (
    input  logic clk,
    input  logic rst,
    input  logic load,              // start of a division
    input  logic step,              // one iteration done
    output logic last
);

    logic [exec_pkg::cnt_w-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (load) begin
            cnt_q <= exec_pkg::cnt_w'(exec_pkg::div_steps);
        end else if (step) begin
            cnt_q <= cnt_q - exec_pkg::cnt_w'(1);
        end
    end

    assign last = (cnt_q == exec_pkg::cnt_w'(1));  // final iteration in progress

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst) step |-> (cnt_q != '0)
    ) else $error("iteration step with counter already at zero");

endmodule

// File: logic/exec_fsm.sv
`timescale 1ns/10ps

module exec_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  exec_pkg::unit_sel_e unit_sel,
    input  logic                cnt_last,
    output logic                alu_load,
    output logic                div_load,
    output logic                div_step,
    output logic                wb_div,
    output logic                busy,
    output logic                done
);

    exec_pkg::exec_state_e state_q;
    exec_pkg::exec_state_e state_d;
    logic                  accept;

    assign accept   = start && (state_q == exec_pkg::st_idle);   // start ignored while busy
    assign alu_load = accept && (unit_sel != exec_pkg::unit_div);
    assign div_load = accept && (unit_sel == exec_pkg::unit_div);
    assign div_step = (state_q == exec_pkg::st_div_run);
    assign wb_div   = (state_q == exec_pkg::st_div_fin);
    assign busy     = (state_q != exec_pkg::st_idle);

    always_comb begin
        state_d = state_q;
        case (state_q)
            exec_pkg::st_idle:    if (div_load) state_d = exec_pkg::st_div_run;
            exec_pkg::st_div_run: if (cnt_last) state_d = exec_pkg::st_div_fin;
            default:              state_d = exec_pkg::st_idle;   // fin writes back
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= exec_pkg::st_idle;
            done    <= 1'b0;
        end else begin
            state_q <= state_d;
            done    <= alu_load || wb_div;   // result register captures on the same edge
        end
    end

    // a second done cycle is only allowed for a new single-cycle op
    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst) done |=> (!done || $past(alu_load))
    ) else $error("done held without a new operation");

    a_busy_ends_with_done: assert property (
        @(posedge clk) disable iff (rst) $fell(busy) |-> done
    ) else $error("busy dropped without done");

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/10ps

module exec_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  exec_pkg::alu_op_e         alu_op,
    input  logic [2:0]                funct3,
    input  logic                      funct7_5,
    input  logic [exec_pkg::xlen-1:0] op_a,
    input  logic [exec_pkg::xlen-1:0] op_b,
    output logic [exec_pkg::xlen-1:0] result,
    output logic                      done,
    output logic                      busy
);

    exec_pkg::alu_ctrl_e       alu_ctrl;
    exec_pkg::mul_ctrl_e       mul_ctrl;
    exec_pkg::div_ctrl_e       div_ctrl;
    exec_pkg::unit_sel_e       unit_sel;
    logic                      alu_load;
    logic                      div_load;
    logic                      div_step;
    logic                      wb_div;
    logic                      cnt_last;
    logic [exec_pkg::xlen-1:0] div_result;

    alu_decoder u_alu_decoder (.alu_op, .funct3, .funct7_5, .alu_ctrl, .mul_ctrl, .div_ctrl,
                               .unit_sel);

    int_alu u_int_alu (.clk, .rst, .op_a, .op_b, .alu_ctrl, .mul_ctrl, .unit_sel, .alu_load,
                       .wb_div, .div_result, .result);

    divider u_divider (.clk, .rst, .op_a, .op_b, .div_ctrl, .div_load, .div_step, .div_result);

    iter_counter u_iter_counter (.clk, .rst, .load(div_load), .step(div_step), .last(cnt_last));

    exec_fsm u_exec_fsm (.clk, .rst, .start, .unit_sel, .cnt_last, .alu_load, .div_load,
                         .div_step, .wb_div, .busy, .done);

    // classes 6 and 7 have no decode
    a_legal_alu_op: assert property (
        @(posedge clk) disable iff (rst) (start && !busy) |-> (alu_op <= exec_pkg::div_op)
    ) else $error("illegal alu_op %0d at start", alu_op);

endmodule

// File: verif/exec_unit_tb.sv
`timescale 1ns/10ps

module exec_unit_tb;

    localparam int n_rand     = 200;
    localparam int lat_single = 1;
    localparam int lat_div    = 34;             // load edge, 32 steps, write-back edge

    typedef struct {
        logic [2:0]  op;
        logic [2:0]  f3;
        logic        f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp;
    } vec_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              start;
    exec_pkg::alu_op_e alu_op;
    logic [2:0]        funct3;
    logic              funct7_5;
    logic [31:0]       op_a;
    logic [31:0]       op_b;
    logic [31:0]       result;
    logic              done;
    logic              busy;

    vec_t vec_q[$];
    int   errors = 0;
    bit   table_ready = 1'b0;

    exec_unit u_exec_unit (.clk, .rst, .start, .alu_op, .funct3, .funct7_5, .op_a, .op_b,
                           .result, .done, .busy);

    always #20 clk = ~clk;

    task automatic add_vec(input logic [2:0] op, input logic [2:0] f3, input logic f7,
                           input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp);
        vec_t v;
        v = '{op: op, f3: f3, f7: f7, a: a, b: b, exp: exp};
        vec_q.push_back(v);
    endtask

    task automatic load_table();
        add_vec(0, 0, 0, 32'h0000_1000, 32'h0000_0024, 32'h0000_1024);  // address add
        add_vec(1, 0, 0, 32'h0000_0005, 32'h0000_0007, 32'hffff_fffe);  // branch sub
        add_vec(3, 0, 0, 32'hdead_beef, 32'h1234_5000, 32'h1234_5000);  // lui
        add_vec(2, 0, 0, 32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000);
        add_vec(2, 0, 1, 32'h0000_0010, 32'h0000_0020, 32'hffff_fff0);
        add_vec(2, 1, 0, 32'h0000_0001, 32'h0000_001f, 32'h8000_0000);
        add_vec(2, 1, 0, 32'h8000_0001, 32'h0000_0021, 32'h0000_0002);  // only shamt bits
        add_vec(2, 2, 0, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0001);
        add_vec(2, 2, 0, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0000);
        add_vec(2, 3, 0, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000);
        add_vec(2, 4, 0, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0);
        add_vec(2, 5, 0, 32'h8000_0000, 32'h0000_0004, 32'h0800_0000);
        add_vec(2, 5, 1, 32'h8000_0000, 32'h0000_0004, 32'hf800_0000);
        add_vec(2, 6, 0, 32'h00ff_0000, 32'h0000_00ff, 32'h00ff_00ff);
        add_vec(2, 7, 0, 32'h1234_5678, 32'h0f0f_0f0f, 32'h0204_0608);
        add_vec(4, 0, 0, 32'h0000_0007, 32'h0000_0006, 32'h0000_002a);
        add_vec(4, 0, 0, 32'hffff_fffd, 32'h0000_0005, 32'hffff_fff1);
        add_vec(4, 1, 0, 32'hffff_fffd, 32'h0000_0005, 32'hffff_ffff);
        add_vec(4, 1, 0, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
        add_vec(4, 1, 0, 32'h7fff_ffff, 32'h7fff_ffff, 32'h3fff_ffff);
        add_vec(4, 2, 0, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);
        add_vec(4, 2, 0, 32'h0000_0002, 32'h8000_0000, 32'h0000_0001);
        add_vec(4, 3, 0, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
        add_vec(5, 4, 0, 32'h0000_0014, 32'h0000_0003, 32'h0000_0006);
        add_vec(5, 4, 0, 32'hffff_ffec, 32'h0000_0003, 32'hffff_fffa);
        add_vec(5, 6, 0, 32'hffff_ffec, 32'h0000_0003, 32'hffff_fffe);
        add_vec(5, 6, 0, 32'h0000_0014, 32'hffff_fffd, 32'h0000_0002);
        add_vec(5, 5, 0, 32'hffff_ffff, 32'h0000_0002, 32'h7fff_ffff);
        add_vec(5, 7, 0, 32'hffff_ffff, 32'h0000_0010, 32'h0000_000f);
        add_vec(5, 4, 0, 32'h0000_1234, 32'h0000_0000, 32'hffff_ffff);  // divide by zero
        add_vec(5, 5, 0, 32'h0000_1234, 32'h0000_0000, 32'hffff_ffff);
        add_vec(5, 6, 0, 32'hffff_fff9, 32'h0000_0000, 32'hffff_fff9);
        add_vec(5, 7, 0, 32'h0000_0055, 32'h0000_0000, 32'h0000_0055);
        add_vec(5, 4, 0, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);  // signed overflow
        add_vec(5, 6, 0, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
    endtask

    // RV32IM result for one operation class and function code
    function automatic logic [31:0] model_result(input logic [2:0] op, input logic [2:0] f3,
                                                 input logic f7, input logic [31:0] a,
                                                 input logic [31:0] b);
        logic signed [63:0] pa;
        logic signed [63:0] pb;
        logic        [63:0] prod;
        logic               sgn;
        logic        [31:0] q;
        logic        [31:0] r;
        case (op)
            3'd0: return a + b;
            3'd1: return a - b;
            3'd3: return b;
            3'd2: begin
                case (f3)
                    3'd0: return f7 ? a - b : a + b;
                    3'd1: return a << b[4:0];
                    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'd3: return (a < b) ? 32'd1 : 32'd0;
                    3'd4: return a ^ b;
                    3'd5: begin
                        if (f7) return $signed(a) >>> b[4:0];
                        else return a >> b[4:0];
                    end
                    3'd6: return a | b;
                    default: return a & b;
                endcase
            end
            3'd4: begin
                pa   = (f3[1:0] == 2'd1 || f3[1:0] == 2'd2) ? {{32{a[31]}}, a} : {32'd0, a};
                pb   = (f3[1:0] == 2'd1) ? {{32{b[31]}}, b} : {32'd0, b};
                prod = pa * pb;
                return (f3[1:0] == 2'd0) ? prod[31:0] : prod[63:32];
            end
            default: begin
                sgn = !f3[0];                                 // div and rem
                if (b == 32'd0) begin
                    q = '1;
                    r = a;
                end else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                    q = a;
                    r = 32'd0;
                end else if (sgn) begin
                    q = $signed(a) / $signed(b);
                    r = $signed(a) % $signed(b);
                end else begin
                    q = a / b;
                    r = a % b;
                end
                return f3[1] ? r : q;
            end
        endcase
    endfunction

    // corner values show up often in the random loop
    function automatic logic [31:0] pick_operand();
        case ($urandom_range(7, 0))
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            2:       return 32'hffff_ffff;
            3:       return 32'h0000_0001;
            default: return $urandom;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, got %h at %0t", name, expected, actual, $time);
            errors++;
        end
    endtask

    task automatic run_op(input vec_t v);
        int   cycles;
        int   exp_lat;
        logic seen;
        exp_lat  = (v.op == 3'd5) ? lat_div : lat_single;
        cycles   = 0;
        seen     = 1'b0;
        alu_op   = exec_pkg::alu_op_e'(v.op);
        funct3   = v.f3;
        funct7_5 = v.f7;
        op_a     = v.a;
        op_b     = v.b;
        start    = 1'b1;
        while (!seen && cycles < exp_lat + 4) begin
            @(posedge clk);
            #2;
            start = 1'b0;
            op_a  = $urandom;                                 // valid only in start cycle
            op_b  = $urandom;
            cycles++;
            if (done) begin
                seen = 1'b1;
            end else begin
                compare_value("busy", {31'd0, exp_lat > 1}, {31'd0, busy});
            end
        end
        if (!seen) begin
            $display("no done within %0d cycles for op %0d funct3 %0d", cycles, v.op, v.f3);
            errors++;
        end else begin
            if (cycles != exp_lat) begin
                $display("done came %0d cycles after start instead of %0d", cycles, exp_lat);
                errors++;
            end
            compare_value("result", v.exp, result);
            compare_value("busy", 32'd0, {31'd0, busy});
        end
        @(posedge clk);
        #2;
        if (done) begin
            $display("done stayed high for more than one cycle at %0t", $time);
            errors++;
        end
    endtask

    // second start lands in the middle of a divide and must be dropped
    task automatic run_ignored_start();
        int done_count;
        int done_cycle;
        done_count = 0;
        done_cycle = 0;
        alu_op     = exec_pkg::div_op;
        funct3     = 3'b100;
        funct7_5   = 1'b0;
        op_a       = 32'd100;
        op_b       = 32'd7;
        start      = 1'b1;
        for (int cycles = 1; cycles <= lat_div + 4; cycles++) begin
            @(posedge clk);
            #2;
            start = (cycles == 10);
            if (cycles == 10) begin
                alu_op = exec_pkg::mem_addr;
                op_a   = 32'd1;
                op_b   = 32'd1;
            end
            if (done) begin
                done_count++;
                done_cycle = cycles;
            end
        end
        if (done_count != 1 || done_cycle != lat_div) begin
            $display("start during busy: %0d done pulses, last after %0d cycles",
                     done_count, done_cycle);
            errors++;
        end
        compare_value("result", 32'd14, result);
    endtask

    initial begin
        longint limit;
        wait (table_ready);
        limit = longint'(vec_q.size() + n_rand + 1) * 40 * 40 + 4 * 40;
        #(limit);
        $display("timeout: run did not finish within %0d ns", limit);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        vec_t v;
        rst      = 1'b1;
        start    = 1'b0;
        alu_op   = exec_pkg::mem_addr;
        funct3   = 3'd0;
        funct7_5 = 1'b0;
        op_a     = 32'd0;
        op_b     = 32'd0;
        void'($urandom(32'hfd8a_fef8));
        load_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        compare_value("done", 32'd0, {31'd0, done});
        compare_value("busy", 32'd0, {31'd0, busy});
        compare_value("result", 32'd0, result);
        foreach (vec_q[i]) run_op(vec_q[i]);
        run_ignored_start();
        for (int i = 0; i < n_rand; i++) begin
            v.op  = 3'($urandom_range(5, 0));
            v.f3  = 3'($urandom);
            v.f7  = 1'($urandom);
            v.a   = pick_operand();
            v.b   = pick_operand();
            v.exp = model_result(v.op, v.f3, v.f7, v.a, v.b);
            run_op(v);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sim.f
common/exec_pkg.sv
logic/alu_decoder.sv
logic/int_alu.sv
divide/divider.sv
divide/iter_counter.sv
logic/exec_fsm.sv
logic/exec_unit.sv
verif/exec_unit_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module exec_unit_tb -Mdir obj_dir
	./obj_dir/Vexec_unit_tb | tee /dev/stderr | grep "Done: no errors" > /dev/null

clean:
	rm -rf obj_dir
